//--- include/render_defines.svh
// Screen, floor and sprite geometry shared by the RTL that decodes raster positions
`ifndef RENDER_DEFINES_SVH
`define RENDER_DEFINES_SVH

// Bus widths
`define COORD_W 10       // Raster row and column
`define SCROLL_W 11      // World scroll offset, wraps at 2048
`define JUMP_W 7         // Goose jump height in rows

// Screen and floor
`define SCREEN_W 640     // Obstacles enter from this column
`define FLOOR_Y 240      // First ground row

// Goose placement and size
`define GOOSE_X 50
`define GOOSE_Y_BASE 200 // Top row when standing
`define GOOSE_W 30
`define GOOSE_H 40

// Front-view tram
`define TRAM_W 30
`define TRAM_H 40

// Square emblem, trails the tram
`define EMBLEM_SIZE 30
`define EMBLEM_OFFSET 250
`define OUTLINE_W 2      // Border thickness of the hollow emblem

`endif

//--- rtl/render_pkg.sv
// Colour type and sprite part encodings shared by the renderer RTL and its testbench
package render_pkg;

    // 2 bits per channel, 6-bit pixel
    typedef struct packed {
        logic [1:0] r;
        logic [1:0] g;
        logic [1:0] b;
    } rgb_t;

    typedef enum logic [2:0] {
        goose_none,
        goose_beak,
        goose_eye,
        goose_head,
        goose_neck,
        goose_wing,
        goose_body,
        goose_legs
    } goose_part_e;

    typedef enum logic [2:0] {
        tram_none,
        tram_headlight,
        tram_blade,
        tram_windshield,
        tram_body,
        tram_roof
    } tram_part_e;

endpackage

//--- rtl/goose_sprite.sv
// Combinational goose decoder, tells whether a raster pixel is on the goose and its colour
`timescale 1ns/1ps
`include "render_defines.svh"

module goose_sprite (
    input  logic [`COORD_W-1:0] haddr,
    input  logic [`COORD_W-1:0] vaddr,
    input  logic [`JUMP_W-1:0]  jump_pos,
    input  logic                game_over,
    input  logic                game_start_blink,
    output logic                goose_hit,
    output render_pkg::rgb_t    goose_color
);

    localparam int unsigned CW = `COORD_W;

    logic [`COORD_W-1:0] goose_top;
    logic [`COORD_W-1:0] row;
    logic [`COORD_W-1:0] col;
    logic                in_box;
    render_pkg::goose_part_e part;

    // Jumping moves the sprite up the screen
    assign goose_top = CW'(`GOOSE_Y_BASE) - CW'(jump_pos);

    assign row = vaddr - goose_top;        // Local row inside the sprite
    assign col = haddr - CW'(`GOOSE_X);    // Local column

    assign in_box = (vaddr >= goose_top) && (row < `GOOSE_H) &&
                    (haddr >= `GOOSE_X) && (col < `GOOSE_W);

    // Parts overlap, earlier checks win
    always_comb begin
        part = render_pkg::goose_none;
        if (in_box && game_start_blink) begin
            if (row inside {[13:14]} && col inside {[27:28]}) begin
                part = render_pkg::goose_beak;
            end else if (row inside {[12:13]} && col == 24) begin
                part = render_pkg::goose_eye;
            end else if (row inside {[11:16]} && col inside {[22:26]}) begin
                part = render_pkg::goose_head;
            end else if (row inside {[17:24]} && col inside {[17:21]}) begin
                part = render_pkg::goose_neck;
            end else if (row inside {[14:24]} && col inside {[6:18]}) begin
                part = render_pkg::goose_wing;
            end else if (row inside {[25:35]} && col inside {[9:22]}) begin
                part = render_pkg::goose_body;
            end else if (row inside {[36:39]} && (col == 12 || col == 15)) begin
                part = render_pkg::goose_legs;
            end
        end
    end

    assign goose_hit = (part != render_pkg::goose_none);

    always_comb begin
        goose_color = '0;
        if (game_over) begin
            goose_color = '{r: 2'd3, g: 2'd0, b: 2'd0};   // Whole goose turns red
        end else begin
            case (part)
                render_pkg::goose_beak: goose_color = '{r: 2'd3, g: 2'd2, b: 2'd1};
                render_pkg::goose_eye:  goose_color = '{r: 2'd3, g: 2'd3, b: 2'd3};
                render_pkg::goose_wing,
                render_pkg::goose_body: goose_color = '{r: 2'd2, g: 2'd2, b: 2'd1}; // Brown
                default:                goose_color = '0;  // Head, neck and legs are black
            endcase
        end
    end

endmodule

//--- rtl/obstacle_sprite.sv
// Combinational decoder for the scrolling tram and emblem obstacles
`timescale 1ns/1ps
`include "render_defines.svh"

module obstacle_sprite (
    input  logic [`COORD_W-1:0]  haddr,
    input  logic [`COORD_W-1:0]  vaddr,
    input  logic [`SCROLL_W-1:0] scrolladdr,
    input  logic [1:0]           obstacle_select,
    input  logic [1:0]           obstacle_type,
    output logic                 tram_hit,
    output render_pkg::rgb_t     tram_color,
    output logic                 emblem_hit
);

    localparam int unsigned CW = `COORD_W;
    localparam int unsigned SW = `SCROLL_W;

    logic [`SCROLL_W-1:0] tram_x;
    logic [`SCROLL_W-1:0] emblem_x;
    logic [`SCROLL_W-1:0] tram_col;
    logic [`SCROLL_W-1:0] emblem_col;
    logic [`COORD_W-1:0]  tram_row;
    logic [`COORD_W-1:0]  emblem_row;
    logic                 tram_in;
    logic                 emblem_in;
    logic                 emblem_edge;
    render_pkg::tram_part_e part;

    // Left columns, modulo 2048 so the world wraps
    assign tram_x   = SW'(`SCREEN_W) - scrolladdr;
    assign emblem_x = tram_x + SW'(`EMBLEM_OFFSET);

    assign tram_col   = SW'(haddr) - tram_x;
    assign emblem_col = SW'(haddr) - emblem_x;
    assign tram_row   = vaddr - CW'(`FLOOR_Y - `TRAM_H);
    assign emblem_row = vaddr - CW'(`FLOOR_Y - `EMBLEM_SIZE);

    // Both obstacles stand on the floor
    assign tram_in = (vaddr >= (`FLOOR_Y - `TRAM_H)) && (vaddr < `FLOOR_Y) &&
                     (tram_col < `TRAM_W);
    assign emblem_in = (vaddr >= (`FLOOR_Y - `EMBLEM_SIZE)) && (vaddr < `FLOOR_Y) &&
                       (emblem_col < `EMBLEM_SIZE);

    always_comb begin
        part = render_pkg::tram_none;
        if (obstacle_select[0] && tram_in) begin
            if (tram_row == 26 && (tram_col inside {[8:10]} || tram_col inside {[20:22]})) begin
                part = render_pkg::tram_headlight;
            end else if (tram_row inside {[8:28]} &&
                         (tram_col inside {[3:4]} || tram_col inside {[25:26]})) begin
                part = render_pkg::tram_blade;     // Blue side strips
            end else if (tram_row inside {[6:24]} && tram_col inside {[5:24]}) begin
                part = render_pkg::tram_windshield;
            end else if (tram_row inside {[25:39]} && tram_col inside {[4:26]}) begin
                part = render_pkg::tram_body;
            end else if (tram_row <= 5 && tram_col inside {[5:24]}) begin
                part = render_pkg::tram_roof;
            end
        end
    end

    assign tram_hit = (part != render_pkg::tram_none);

    always_comb begin
        case (part)
            render_pkg::tram_headlight,
            render_pkg::tram_body:  tram_color = '{r: 2'd3, g: 2'd3, b: 2'd3};
            render_pkg::tram_blade,
            render_pkg::tram_roof:  tram_color = '{r: 2'd0, g: 2'd1, b: 2'd3};
            default:                tram_color = '0;    // Black glass, unused when no hit
        endcase
    end

    // Hollow emblem keeps only a border of OUTLINE_W pixels
    assign emblem_edge = (emblem_col < `OUTLINE_W) ||
                         (emblem_col >= (`EMBLEM_SIZE - `OUTLINE_W)) ||
                         (emblem_row < `OUTLINE_W) ||
                         (emblem_row >= (`EMBLEM_SIZE - `OUTLINE_W));

    assign emblem_hit = obstacle_select[1] && emblem_in && (obstacle_type[1] || emblem_edge);

endmodule

//--- rtl/layer_stage.sv
// Pipeline register holding one pixel's layer flags, sprite colours and display flag
`timescale 1ns/1ps
`include "render_defines.svh"

module layer_stage (
    input  logic                clk,
    input  logic                sys_rst,
    input  logic [`COORD_W-1:0] vaddr,
    input  logic                display_on,
    input  logic                goose_hit,
    input  render_pkg::rgb_t    goose_color,
    input  logic                tram_hit,
    input  render_pkg::rgb_t    tram_color,
    input  logic                emblem_hit,
    output logic                goose_q,
    output logic                tram_q,
    output logic                emblem_q,
    output logic                ground_q,
    output render_pkg::rgb_t    goose_color_q,
    output render_pkg::rgb_t    tram_color_q,
    output logic                visible_q
);

    always_ff @(posedge clk) begin
        if (sys_rst) begin
            goose_q       <= 1'b0;
            tram_q        <= 1'b0;
            emblem_q      <= 1'b0;
            ground_q      <= 1'b0;
            goose_color_q <= '0;
            tram_color_q  <= '0;
            visible_q     <= 1'b0;
        end else begin
            // Layers only exist inside the active area
            goose_q       <= display_on & goose_hit;
            tram_q        <= display_on & tram_hit;
            emblem_q      <= display_on & emblem_hit;
            ground_q      <= display_on & (vaddr >= `FLOOR_Y);  // Sky is whatever is left
            goose_color_q <= goose_color;
            tram_color_q  <= tram_color;
            visible_q     <= display_on;
        end
    end

endmodule

//--- rtl/compositor.sv
// Combinational layer mixer producing the output pixel and the collision flag
`timescale 1ns/1ps

module compositor (
    input  logic             goose_q,
    input  logic             tram_q,
    input  logic             emblem_q,
    input  logic             ground_q,
    input  render_pkg::rgb_t goose_color_q,
    input  render_pkg::rgb_t tram_color_q,
    input  logic             visible_q,
    output render_pkg::rgb_t pixel,
    output logic             collision
);

    // Front to back: goose, tram, emblem, ground, sky
    always_comb begin
        if (!visible_q) begin
            pixel = '0;                                  // Blanking
        end else if (goose_q) begin
            pixel = goose_color_q;
        end else if (tram_q) begin
            pixel = tram_color_q;
        end else if (emblem_q) begin
            pixel = '{r: 2'd3, g: 2'd3, b: 2'd3};
        end else if (ground_q) begin
            pixel = '{r: 2'd1, g: 2'd1, b: 2'd1};       // Grey ground
        end else begin
            pixel = '{r: 2'd0, g: 2'd3, b: 2'd3};       // Cyan sky
        end
    end

    assign collision = goose_q & (tram_q | emblem_q);

endmodule

//--- rtl/game_renderer.sv
// Renderer top level, one raster pixel in per clock and its colour out one cycle later
`timescale 1ns/1ps
`include "render_defines.svh"

module game_renderer (
    input  logic                 clk,
    input  logic                 sys_rst,
    input  logic [`COORD_W-1:0]  vaddr,
    input  logic [`COORD_W-1:0]  haddr,
    input  logic [`SCROLL_W-1:0] scrolladdr,
    input  logic [`JUMP_W-1:0]   jump_pos,
    input  logic [1:0]           obstacle_select,
    input  logic [1:0]           obstacle_type,
    input  logic                 game_over,
    input  logic                 game_start_blink,
    input  logic                 display_on,
    output render_pkg::rgb_t     pixel,
    output logic                 collision
);

    logic             goose_hit;
    logic             tram_hit;
    logic             emblem_hit;
    render_pkg::rgb_t goose_color;
    render_pkg::rgb_t tram_color;

    // Registered layer set of the pixel in flight
    logic             goose_q;
    logic             tram_q;
    logic             emblem_q;
    logic             ground_q;
    logic             visible_q;
    render_pkg::rgb_t goose_color_q;
    render_pkg::rgb_t tram_color_q;

    goose_sprite u_goose (
        .haddr            (haddr),
        .vaddr            (vaddr),
        .jump_pos         (jump_pos),
        .game_over        (game_over),
        .game_start_blink (game_start_blink),
        .goose_hit        (goose_hit),
        .goose_color      (goose_color)
    );

    obstacle_sprite u_obstacle (
        .haddr           (haddr),
        .vaddr           (vaddr),
        .scrolladdr      (scrolladdr),
        .obstacle_select (obstacle_select),
        .obstacle_type   (obstacle_type),
        .tram_hit        (tram_hit),
        .tram_color      (tram_color),
        .emblem_hit      (emblem_hit)
    );

    layer_stage u_layers (
        .clk           (clk),
        .sys_rst       (sys_rst),
        .vaddr         (vaddr),
        .display_on    (display_on),
        .goose_hit     (goose_hit),
        .goose_color   (goose_color),
        .tram_hit      (tram_hit),
        .tram_color    (tram_color),
        .emblem_hit    (emblem_hit),
        .goose_q       (goose_q),
        .tram_q        (tram_q),
        .emblem_q      (emblem_q),
        .ground_q      (ground_q),
        .goose_color_q (goose_color_q),
        .tram_color_q  (tram_color_q),
        .visible_q     (visible_q)
    );

    compositor u_compositor (
        .goose_q       (goose_q),
        .tram_q        (tram_q),
        .emblem_q      (emblem_q),
        .ground_q      (ground_q),
        .goose_color_q (goose_color_q),
        .tram_color_q  (tram_color_q),
        .visible_q     (visible_q),
        .pixel         (pixel),
        .collision     (collision)
    );

endmodule

//--- bench/renderer_properties.sv
// Assertions on the layer register, attached to every layer_stage instance through bind
`timescale 1ns/1ps

module renderer_properties (
    input logic clk,
    input logic sys_rst,
    input logic goose_q,
    input logic tram_q,
    input logic emblem_q,
    input logic ground_q,
    input logic visible_q
);

    // Reset leaves no layer and a blanked pixel
    assert property (@(posedge clk)
        sys_rst |=> !(goose_q || tram_q || emblem_q || ground_q || visible_q))
    else $error("Layer register not cleared after reset");

    // Outside the active area no layer survives
    assert property (@(posedge clk) disable iff (sys_rst)
        !visible_q |-> !(goose_q || tram_q || emblem_q || ground_q))
    else $error("Layer flag set while the display is off");

endmodule

bind layer_stage renderer_properties u_properties (.*);

//--- bench/tb_game_renderer.sv
// Testbench for game_renderer, replays the pattern vectors and checks pixel and collision
`timescale 1ns/1ps
`include "render_defines.svh"

module tb_game_renderer;

    localparam int FIELDS         = 13;  // Words per vector in the pattern file
    localparam int MAX_VECTORS    = 64;
    localparam int TIMEOUT_CYCLES = 2 * MAX_VECTORS + 20;

    logic                 clk = 1'b0;
    logic                 sys_rst;
    logic [`COORD_W-1:0]  vaddr;
    logic [`COORD_W-1:0]  haddr;
    logic [`SCROLL_W-1:0] scrolladdr;
    logic [`JUMP_W-1:0]   jump_pos;
    logic [1:0]           obstacle_select;
    logic [1:0]           obstacle_type;
    logic                 game_over;
    logic                 game_start_blink;
    logic                 display_on;
    render_pkg::rgb_t     pixel;
    logic                 collision;

    logic [15:0] patterns [0:MAX_VECTORS*FIELDS-1];
    int          cycles = 0;

    game_renderer DUT (.*);

    always #4 clk = ~clk;  // 8 ns period

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped on failure");
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            abort_run("Simulation timed out before all vectors were checked");
        end
    end

    task automatic check_pixel(input render_pkg::rgb_t expected, input int vector);
        if (pixel !== expected) begin
            $display("FAIL t=%0t pixel vector %0d expected %0d,%0d,%0d actual %0d,%0d,%0d",
                     $time, vector, expected.r, expected.g, expected.b,
                     pixel.r, pixel.g, pixel.b);
            abort_run("Pixel colour differs from the expected value");
        end
    endtask

    task automatic check_collision(input logic expected, input int vector);
        if (collision !== expected) begin
            $display("FAIL t=%0t collision vector %0d expected %b actual %b",
                     $time, vector, expected, collision);
            abort_run("Collision flag differs from the expected value");
        end
    endtask

    // Last three colour words plus collision word close each vector
    function automatic render_pkg::rgb_t expected_pixel(input int base);
        render_pkg::rgb_t px;
        px.r = patterns[base + 9][1:0];
        px.g = patterns[base + 10][1:0];
        px.b = patterns[base + 11][1:0];
        return px;
    endfunction

    task automatic apply_vector(input int base);
        vaddr            = patterns[base][`COORD_W-1:0];
        haddr            = patterns[base + 1][`COORD_W-1:0];
        scrolladdr       = patterns[base + 2][`SCROLL_W-1:0];
        jump_pos         = patterns[base + 3][`JUMP_W-1:0];
        obstacle_select  = patterns[base + 4][1:0];
        obstacle_type    = patterns[base + 5][1:0];
        game_over        = patterns[base + 6][0];
        game_start_blink = patterns[base + 7][0];
        display_on       = patterns[base + 8][0];
    endtask

    task automatic find_vector_count(output int n);
        n = 0;
        while (n < MAX_VECTORS && patterns[n*FIELDS] !== 16'hffff) begin
            if ($isunknown(patterns[n*FIELDS])) begin
                abort_run("Pattern file ends without its end marker");
            end
            n++;
        end
        if (n == MAX_VECTORS) begin
            abort_run("Pattern file holds more vectors than the testbench can store");
        end
    endtask

    initial begin
        int count;
        sys_rst = 1'b1;
        vaddr = 10'd220;           // Goose wing over the tram, so only reset keeps both low
        haddr = 10'd60;
        scrolladdr = 11'h24e;
        jump_pos = '0;
        obstacle_select = 2'b01;
        obstacle_type = 2'b00;
        game_over = 1'b0;
        game_start_blink = 1'b1;
        display_on = 1'b1;
        $readmemh("bench/render_patterns.txt", patterns);
        find_vector_count(count);
        repeat (3) begin
            @(posedge clk);
            @(negedge clk);
            check_pixel('0, -1);   // Vector -1 marks the reset checks
            check_collision(1'b0, -1);
        end
        sys_rst = 1'b0;
        for (int i = 0; i < count; i++) begin
            apply_vector(i * FIELDS);
            @(negedge clk);          // Result of the vector after one rising edge
            check_pixel(expected_pixel(i * FIELDS), i);
            check_collision(patterns[i*FIELDS + 12][0], i);
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- bench/render_patterns.txt
// vaddr haddr scrolladdr jump_pos obstacle_select obstacle_type game_over blink display_on
// then expected r g b collision, all hex, a vaddr of ffff ends the list
064 12c 000 00 0 0 0 1 1 0 3 3 0
0f0 12c 000 00 0 0 0 1 1 1 1 1 0
064 12c 000 00 0 0 0 1 0 0 0 0 0
0d5 04d 000 00 0 0 0 1 0 0 0 0 0
0d5 04d 000 00 0 0 0 1 1 3 2 1 0
0d4 04a 000 00 0 0 0 1 1 3 3 3 0
0d3 048 000 00 0 0 0 1 1 0 0 0 0
0dc 03c 000 00 0 0 0 1 1 2 2 1 0
0ee 03e 000 00 0 0 0 1 1 0 0 0 0
0ad 04d 000 28 0 0 0 1 1 3 2 1 0
0b4 03c 000 28 0 0 0 1 1 2 2 1 0
0d5 04d 000 00 0 0 1 1 1 3 0 0 0
0d4 04a 000 00 0 0 1 1 1 3 0 0 0
0d5 04d 000 00 0 0 0 0 1 0 3 3 0
0e2 198 0f0 00 1 0 0 1 1 3 3 3 0
0d2 193 0f0 00 1 0 0 1 1 0 1 3 0
0d2 19c 0f0 00 1 0 0 1 1 0 0 0 0
0e6 19f 0f0 00 1 0 0 1 1 3 3 3 0
0ca 08a 200 00 1 0 0 1 1 0 1 3 0
0e6 09e 200 00 1 0 0 1 1 0 3 3 0
0e6 38f 700 00 1 0 0 1 1 3 3 3 0
0e6 38f 700 00 0 0 0 1 1 0 3 3 0
0e1 299 0f0 00 2 2 0 1 1 3 3 3 0
0e1 299 0f0 00 2 0 0 1 1 0 3 3 0
0e1 28a 0f0 00 2 0 0 1 1 3 3 3 0
0dc 03c 24e 00 1 0 0 1 1 2 2 1 1
0d5 04d 24e 00 1 0 0 1 1 3 2 1 0
0e6 041 348 00 2 2 0 1 1 2 2 1 1
ffff

//--- sim.f
+incdir+include
rtl/render_pkg.sv
rtl/goose_sprite.sv
rtl/obstacle_sprite.sv
rtl/layer_stage.sv
rtl/compositor.sv
rtl/game_renderer.sv
bench/renderer_properties.sv
bench/tb_game_renderer.sv

//--- Bender.yml
package:
  name: game_renderer

export_include_dirs:
  - include

sources:
  - rtl/render_pkg.sv
  - rtl/goose_sprite.sv
  - rtl/obstacle_sprite.sv
  - rtl/layer_stage.sv
  - rtl/compositor.sv
  - rtl/game_renderer.sv
  - target: test
    files:
      - bench/renderer_properties.sv
      - bench/tb_game_renderer.sv
